// ==== source/out_geom_pkg.sv ====
package out_geom_pkg;

  // largest kernel width handled by the column tables
  localparam int KW_MAX = 7;

  // width of the half kernel width field
  localparam int KW2_BITS = $clog2(KW_MAX + 1);

  // requant shift field, covers the whole accumulator
  localparam int SHIFT_BITS = 5;

  // half kernel width, kernel is 2*kw2+1
  typedef logic [KW2_BITS-1:0] kw2_t;

  // requant setup, carried in element [0][0] of a config word
  typedef struct packed {
    logic [SHIFT_BITS-1:0] shift; // arithmetic right shift amount
    logic                  sat_en; // clamp to output range, else wrap
  } rq_cfg_st;

  // value after reset: no shift, saturate
  localparam rq_cfg_st RQ_CFG_RESET = '{shift: '0, sat_en: 1'b1};

endpackage

// ==== source/out_stream_pkg.sv ====
package out_stream_pkg;

  // element width, the Y_BITS module parameter has to match this
  localparam int ELEM_BITS = 16;

  localparam int CFG_PAD_BITS = ELEM_BITS - $bits(out_geom_pkg::rq_cfg_st);

  // sideband travelling with every input word
  typedef struct packed {
    out_geom_pkg::kw2_t kw2;
    logic               is_config;      // word carries configuration, not data
    logic               is_w_first_kw2; // leading columns of a row, dropped
    logic               is_w_last;      // last word of a row keeps the tail columns
  } tuser_st;

  // config record sits in the low bits of the element
  typedef struct packed {
    logic [CFG_PAD_BITS-1:0]   pad;
    out_geom_pkg::rq_cfg_st    rq;
  } cfg_elem_st;

  // one array element, read as accumulator or as config
  typedef union packed {
    logic signed [ELEM_BITS-1:0] acc;
    cfg_elem_st                  cfg;
  } elem_u;

endpackage

// ==== source/out_col_decode.sv ====
`timescale 1ns/1ns

module out_col_decode #(
  parameter int ROWS   = 4,
  parameter int COLS   = 8,
  parameter int Y_BITS = 16
) (
  input  logic                                   aclk,
  input  logic                                   aresetn,

  input  logic                                   s_valid,
  input  logic                                   s_last,
  input  out_stream_pkg::tuser_st                s_user,
  input  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0]  s_data,
  output logic                                   s_ready,

  output logic                                   d_valid,
  output logic                                   d_last,
  output logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0]  d_data,
  output logic [COLS-1:0]                        d_col_valid,
  output logic [COLS-1:0]                        d_col_last,
  input  logic                                   d_ready,

  output out_geom_pkg::rq_cfg_st                 rq_cfg
);

  localparam int N_KW2 = 2 ** $bits(out_geom_pkg::kw2_t); // one table row per kw2 code

  logic [N_KW2-1:0][COLS-1:0] lut_valid, lut_tail, lut_last;
  logic [COLS-1:0]            sel_valid;
  logic                       keep, take;
  out_stream_pkg::elem_u      elem0;

  // column c = ci+1, kernel k = 2*k2+1
  for (genvar k2 = 0; k2 < N_KW2; k2++) begin : g_kw
    for (genvar ci = 0; ci < COLS; ci++) begin : g_col
      localparam int K = 2 * k2 + 1;
      localparam int C = ci + 1;
      assign lut_valid[k2][ci] = (C % K) == 0;
      assign lut_tail[k2][ci]  = (C % K) > k2; // partial window at row end
      assign lut_last[k2][ci]  = C == k2 + 1;
    end
  end

  assign keep      = !s_user.is_config && !s_user.is_w_first_kw2;
  assign sel_valid = lut_valid[s_user.kw2] | (lut_tail[s_user.kw2] & {COLS{s_user.is_w_last}});
  assign elem0     = s_data[0][0];

  assign s_ready = !d_valid || d_ready;
  assign take    = s_valid && s_ready;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      d_valid <= 1'b0;
      rq_cfg  <= out_geom_pkg::RQ_CFG_RESET;
    end else begin
      if (s_ready)
        d_valid <= s_valid && keep; // dropped words leave the register empty
      if (take && s_user.is_config)
        rq_cfg <= elem0.cfg.rq;
    end
  end

  always_ff @(posedge aclk) begin
    if (take && keep) begin
      d_data      <= s_data;
      d_last      <= s_last;
      d_col_valid <= sel_valid;
      d_col_last  <= lut_last[s_user.kw2] & sel_valid & {COLS{s_last}};
    end
  end

endmodule

// ==== source/out_col_shift.sv ====
`timescale 1ns/1ns

module out_col_shift #(
  parameter int ROWS   = 4,
  parameter int COLS   = 8,
  parameter int Y_BITS = 16
) (
  input  logic                                   aclk,
  input  logic                                   aresetn,

  input  logic                                   d_valid,
  input  logic                                   d_last,
  input  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0]  d_data,
  input  logic [COLS-1:0]                        d_col_valid,
  input  logic [COLS-1:0]                        d_col_last,
  output logic                                   d_ready,

  output logic                                   x_valid,
  output logic                                   x_last,
  output logic [ROWS-1:0][Y_BITS-1:0]            x_data,
  input  logic                                   x_ready
);

  localparam int CW = $clog2(COLS + 1);

  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0] shift_data;
  logic [COLS-1:0]                       shift_valid, shift_last;
  logic [CW-1:0]                         cnt; // columns left in the word
  logic                                  busy; // low = idle, high = shifting
  logic                                  load, step;

  assign d_ready = !busy;
  assign load    = d_valid && !busy;
  assign step    = busy && x_ready; // empty columns still consume a ready cycle

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      busy        <= 1'b0;
      cnt         <= CW'(COLS);
      shift_valid <= '0;
      shift_last  <= '0;
    end else if (load) begin
      busy        <= 1'b1;
      shift_valid <= d_col_valid;
      shift_last  <= d_col_last & {COLS{d_last}};
    end else if (step) begin
      shift_valid <= shift_valid << 1;
      shift_last  <= shift_last << 1;
      if (cnt == CW'(1)) begin
        busy <= 1'b0;
        cnt  <= CW'(COLS);
      end else begin
        cnt <= cnt - CW'(1);
      end
    end
  end

  // top column is presented, data moves up one column per step
  always_ff @(posedge aclk) begin
    if (load)
      shift_data <= d_data;
    else if (step)
      shift_data <= shift_data << (ROWS * Y_BITS);
  end

  assign x_data  = shift_data[COLS-1];
  assign x_valid = shift_valid[COLS-1];
  assign x_last  = shift_last[COLS-1];

endmodule

// ==== source/out_requant.sv ====
`timescale 1ns/1ns

module out_requant #(
  parameter int ROWS     = 4,
  parameter int Y_BITS   = 16,
  parameter int OUT_BITS = 8
) (
  input  logic                                 aclk,
  input  logic                                 aresetn,

  input  logic                                 x_valid,
  input  logic                                 x_last,
  input  logic [ROWS-1:0][Y_BITS-1:0]          x_data,
  output logic                                 x_ready,

  input  out_geom_pkg::rq_cfg_st               rq_cfg,

  output logic                                 m_valid,
  output logic                                 m_last,
  output logic signed [ROWS-1:0][OUT_BITS-1:0] m_data,
  input  logic                                 m_ready
);

  // headroom for the rounding offset at the largest shift
  localparam int W = Y_BITS + 2 ** out_geom_pkg::SHIFT_BITS;

  localparam logic signed [W-1:0] SAT_MAX = (W'(1) << (OUT_BITS - 1)) - W'(1);
  localparam logic signed [W-1:0] SAT_MIN = -(W'(1) << (OUT_BITS - 1));

  function automatic logic [OUT_BITS-1:0] requant(input logic signed [Y_BITS-1:0] acc,
                                                  input out_geom_pkg::rq_cfg_st cfg);
    logic signed [W-1:0] wide;
    logic signed [W-1:0] half;
    wide = acc;
    half = '0;
    if (cfg.shift != '0)
      half = W'(1) << (cfg.shift - 1'b1); // round half up
    wide = (wide + half) >>> cfg.shift;
    if (cfg.sat_en && wide > SAT_MAX)
      return SAT_MAX[OUT_BITS-1:0];
    if (cfg.sat_en && wide < SAT_MIN)
      return SAT_MIN[OUT_BITS-1:0];
    return wide[OUT_BITS-1:0]; // wraps when saturation is off
  endfunction

  assign x_ready = !m_valid || m_ready;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else if (x_ready) begin
      m_valid <= x_valid;
      m_last  <= x_last;
    end
  end

  always_ff @(posedge aclk) begin
    if (x_ready && x_valid) begin
      for (int r = 0; r < ROWS; r++)
        m_data[r] <= requant(x_data[r], rq_cfg);
    end
  end

endmodule

// ==== source/out_stage_top.sv ====
`timescale 1ns/1ns

module out_stage_top #(
  parameter int ROWS     = 4,
  parameter int COLS     = 8,
  parameter int Y_BITS   = 16,
  parameter int OUT_BITS = 8
) (
  input  logic                                  aclk,
  input  logic                                  aresetn,

  input  logic                                  s_valid,
  input  logic                                  s_last,
  input  out_stream_pkg::tuser_st               s_user,
  input  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0] s_data,
  output logic                                  s_ready,

  output logic                                  m_valid,
  output logic                                  m_last,
  output logic signed [ROWS-1:0][OUT_BITS-1:0]  m_data,
  input  logic                                  m_ready
);

  // decode -> shift
  logic                                  d_valid, d_last, d_ready;
  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0] d_data;
  logic [COLS-1:0]                       d_col_valid, d_col_last;

  // shift -> requant, one column per beat
  logic                                  x_valid, x_last, x_ready;
  logic [ROWS-1:0][Y_BITS-1:0]           x_data;

  out_geom_pkg::rq_cfg_st                rq_cfg;

  out_col_decode #(.ROWS(ROWS), .COLS(COLS), .Y_BITS(Y_BITS)) u_decode (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_valid     (s_valid),
    .s_last      (s_last),
    .s_user      (s_user),
    .s_data      (s_data),
    .s_ready     (s_ready),
    .d_valid     (d_valid),
    .d_last      (d_last),
    .d_data      (d_data),
    .d_col_valid (d_col_valid),
    .d_col_last  (d_col_last),
    .d_ready     (d_ready),
    .rq_cfg      (rq_cfg)
  );

  out_col_shift #(.ROWS(ROWS), .COLS(COLS), .Y_BITS(Y_BITS)) u_shift (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .d_valid     (d_valid),
    .d_last      (d_last),
    .d_data      (d_data),
    .d_col_valid (d_col_valid),
    .d_col_last  (d_col_last),
    .d_ready     (d_ready),
    .x_valid     (x_valid),
    .x_last      (x_last),
    .x_data      (x_data),
    .x_ready     (x_ready)
  );

  out_requant #(.ROWS(ROWS), .Y_BITS(Y_BITS), .OUT_BITS(OUT_BITS)) u_requant (
    .aclk    (aclk),
    .aresetn (aresetn),
    .x_valid (x_valid),
    .x_last  (x_last),
    .x_data  (x_data),
    .x_ready (x_ready),
    .rq_cfg  (rq_cfg),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data),
    .m_ready (m_ready)
  );

endmodule

// ==== dv/out_stage_sva.sv ====
`timescale 1ns/1ns

module out_stage_sva #(
  parameter int ROWS     = 4,
  parameter int COLS     = 8,
  parameter int OUT_BITS = 8
) (
  input logic                          aclk,
  input logic                          aresetn,
  input logic                          d_valid,
  input logic                          d_ready,
  input logic                          m_valid,
  input logic                          m_last,
  input logic [ROWS-1:0][OUT_BITS-1:0] m_data,
  input logic                          m_ready
);

  int unsigned busy_age; // cycles since the shift loaded a word

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn)
      busy_age <= 0;
    else if (d_valid && d_ready)
      busy_age <= 1;
    else if (busy_age != 0 && busy_age < COLS)
      busy_age <= busy_age + 1;
    else
      busy_age <= 0;
  end

  a_reset_idle: assert property (@(posedge aclk) !aresetn |-> !m_valid)
    else $error("m_valid high during reset");

  a_out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> $stable(m_data) && $stable(m_last))
    else $error("m_data or m_last changed while stalled");

  // shift holds off the decode register for all COLS columns
  a_shift_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    busy_age != 0 |-> !d_ready)
    else $error("shift ready again before all columns were stepped");

  a_last_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    m_last |-> m_valid)
    else $error("m_last seen without m_valid");

endmodule

// ==== dv/out_stage_tb.sv ====
`timescale 1ns/1ns

module out_stage_tb;

  localparam int ROWS      = 4;
  localparam int COLS      = 8;
  localparam int Y_BITS    = 16;
  localparam int OUT_BITS  = 8;
  localparam int MAX_WORDS = 32;
  localparam int MAX_BEATS = 64;
  localparam int TIMEOUT   = 400; // cycles allowed per wait

  logic                                  aclk, aresetn;
  logic                                  s_valid, s_last, s_ready;
  out_stream_pkg::tuser_st               s_user;
  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0] s_data;
  logic                                  m_valid, m_last;
  logic signed [ROWS-1:0][OUT_BITS-1:0]  m_data;
  logic                                  m_ready = 1'b1;
  bit                                    random_mode;

  // vectors as read from the file
  out_stream_pkg::tuser_st               in_user [MAX_WORDS];
  logic                                  in_last [MAX_WORDS];
  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0] in_data [MAX_WORDS];
  int                                    in_beats_before [MAX_WORDS];
  logic [ROWS-1:0][OUT_BITS-1:0]         exp_data [MAX_BEATS];
  logic                                  exp_last [MAX_BEATS];
  int                                    n_words, n_beats, n_seen;

  out_stage_top #(.ROWS(ROWS), .COLS(COLS), .Y_BITS(Y_BITS), .OUT_BITS(OUT_BITS)) u_dut (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_user  (s_user),
    .s_data  (s_data),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data),
    .m_ready (m_ready)
  );

  bind out_stage_top out_stage_sva #(.ROWS(ROWS), .COLS(COLS), .OUT_BITS(OUT_BITS)) u_sva (
    .aclk    (aclk),
    .aresetn (aresetn),
    .d_valid (d_valid),
    .d_ready (d_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data),
    .m_ready (m_ready)
  );

  always #50 aclk = ~aclk;

  always @(negedge aclk)
    m_ready <= random_mode ? ($urandom_range(9) >= 3) : 1'b1; // low about 30%

  task automatic fail_now(string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_val(string name, logic [31:0] exp_v, logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, exp_v, act_v);
      fail_now($sformatf("mismatch on %s", name));
    end
  endtask

  task automatic read_vectors();
    int                  fd, n, kw2, is_cfg, first, wlast, last;
    string               line;
    logic [Y_BITS-1:0]   step;
    logic [Y_BITS-1:0]   v [COLS];
    logic [OUT_BITS-1:0] e [ROWS];
    fd = $fopen("dv/out_stage_vectors.txt", "r");
    if (fd == 0)
      fail_now("cannot open dv/out_stage_vectors.txt");
    n_words = 0;
    n_beats = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#")
        continue;
      if (line[0] == "I") begin
        n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h", kw2, is_cfg, first,
                    wlast, last, step, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
        if (n != 14 || n_words == MAX_WORDS)
          fail_now("bad input line in the vector file");
        in_user[n_words] = '{kw2: out_geom_pkg::kw2_t'(kw2), is_config: is_cfg[0],
                             is_w_first_kw2: first[0], is_w_last: wlast[0]};
        in_last[n_words] = last[0];
        in_beats_before[n_words] = n_beats;
        for (int c = 0; c < COLS; c++)
          for (int r = 0; r < ROWS; r++)
            in_data[n_words][c][r] = v[c] + step * Y_BITS'(r);
        n_words++;
      end else if (line[0] == "E") begin
        n = $sscanf(line, "E %h %h %h %h %h", last, e[0], e[1], e[2], e[3]);
        if (n != 5 || n_beats == MAX_BEATS)
          fail_now("bad expect line in the vector file");
        exp_last[n_beats] = last[0];
        for (int r = 0; r < ROWS; r++)
          exp_data[n_beats][r] = e[r];
        n_beats++;
      end else begin
        fail_now("unknown line type in the vector file");
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_reset();
    @(negedge aclk);
    aresetn = 1'b0;
    repeat (2) @(negedge aclk);
    aresetn = 1'b1;
  endtask

  // hold the word until the posedge that takes it
  task automatic send_word(int w);
    int t;
    s_user  = in_user[w];
    s_last  = in_last[w];
    s_data  = in_data[w];
    s_valid = 1'b1;
    t = 0;
    while (!s_ready) begin
      @(negedge aclk);
      t++;
      if (t > TIMEOUT)
        fail_now($sformatf("timeout waiting for s_ready on input word %0d", w));
    end
    @(negedge aclk);
    s_valid = 1'b0;
  endtask

  task automatic wait_beats(int target);
    int t;
    t = 0;
    while (n_seen < target) begin
      @(negedge aclk);
      t++;
      if (t > TIMEOUT)
        fail_now($sformatf("timeout waiting for output beat %0d", n_seen));
    end
  endtask

  always @(posedge aclk) begin
    if (!aresetn) begin
      n_seen = 0;
    end else if (m_valid && m_ready) begin
      if (n_seen >= n_beats) begin
        fail_now("output beat beyond the expected sequence");
      end else begin
        for (int r = 0; r < ROWS; r++)
          check_val($sformatf("m_data[%0d]", r), exp_data[n_seen][r], m_data[r]);
        check_val("m_last", exp_last[n_seen], m_last);
        n_seen++;
      end
    end
  end

  initial begin
    void'($urandom(48637));
    aclk    = 1'b0;
    aresetn = 1'b0;
    s_valid = 1'b0;
    s_last  = 1'b0;
    s_user  = '0;
    s_data  = '0;
    read_vectors();
    // first pass streams freely, second adds stalls and gaps
    for (int pass = 0; pass < 2; pass++) begin
      random_mode = (pass == 1);
      apply_reset();
      check_val("s_ready", 1'b1, s_ready); // empty pipeline takes a word
      check_val("m_valid", 1'b0, m_valid);
      for (int w = 0; w < n_words; w++) begin
        if (in_user[w].is_config)
          wait_beats(in_beats_before[w]); // earlier words keep the old shift
        if (random_mode)
          repeat ($urandom_range(2)) @(negedge aclk);
        send_word(w);
      end
      wait_beats(n_beats);
      repeat (4 * COLS) @(negedge aclk); // room for any stray beat
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== dv/out_stage_vectors.txt ====
# I kw2 is_config is_w_first_kw2 is_w_last s_last row_step col1 .. col8, hex
# element [c][r] = col_c + r * row_step; E m_last row0 row1 row2 row3, hex
I 1 0 0 0 0 0001 0010 0020 0030 0040 0050 0060 0070 0080
E 0 60 61 62 63
E 0 30 31 32 33
I 1 0 0 1 1 0002 0001 0002 0003 0004 0005 0006 0007 0008
E 0 08 0a 0c 0e
E 0 06 08 0a 0c
E 0 05 07 09 0b
E 0 03 05 07 09
E 1 02 04 06 08
I 2 0 1 0 0 0000 0077 0077 0077 0077 0077 0077 0077 0077
I 2 0 0 1 1 ffff fff0 ffe0 ffd0 ffc0 ffb0 ffa0 ff90 ff80
E 0 80 80 80 80
E 0 b0 af ae ad
E 0 c0 bf be bd
E 1 d0 cf ce cd
I 2 0 0 0 1 0001 0000 0000 0000 0000 0123 0000 0000 0000
E 0 7f 7f 7f 7f
# config shift 4 with saturation
I 0 1 0 0 0 0000 0009 0000 0000 0000 0000 0000 0000 0000
I 0 0 0 1 1 0001 0006 fff6 7ff0 8000 07e6 f807 0000 0100
E 0 10 10 10 10
E 0 00 00 00 00
E 0 80 81 81 81
E 0 7e 7e 7f 7f
E 0 80 80 80 80
E 0 7f 7f 7f 7f
E 0 ff ff 00 00
E 1 00 00 01 01
# config shift 4, wrap to the low bits
I 0 1 0 0 0 0000 0008 0000 0000 0000 0000 0000 0000 0000
I 1 0 0 0 0 0100 0000 0000 8000 0000 0000 1230 0000 0000
E 0 23 33 43 53
E 0 00 10 20 30

// ==== filelist.f ====
source/out_geom_pkg.sv
source/out_stream_pkg.sv
source/out_col_decode.sv
source/out_col_shift.sv
source/out_requant.sv
source/out_stage_top.sv
dv/out_stage_sva.sv
dv/out_stage_tb.sv

// ==== Makefile ====
TOP = out_stage_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir
